// ==== Bender.yml ====
package:
  name: adc_stream

sources:
  - include_dirs:
      - design
    files:
      - design/adc_stream_pkg.sv
      - design/adc_sample_packer.sv
      - design/sample_fifo.sv
      - design/packet_sender.sv
      - design/adc_stream_top.sv

  - target: test
    include_dirs:
      - design
    files:
      - tests/tb_adc_stream.sv

// ==== design/adc_sample_packer.sv ====
`timescale 1ns/1ps

module adc_sample_packer (
	input  logic                        GMII_GTX_CLK_int,
	input  logic                        rst_100,
	input  logic                        adc_strobe_i,
	input  adc_stream_pkg::adc_sample_t adc_cha_i,
	input  adc_stream_pkg::adc_sample_t adc_chb_i,
	input  logic                        fifo_full_i,
	output logic                        fifo_wr_o,
	output adc_stream_pkg::sample_word_t fifo_wr_data_o,
	output adc_stream_pkg::drop_count_t  drop_count_o
);
	import adc_stream_pkg::*;

	sample_word_t word_q;
	logic         wr_q;
	drop_count_t  drop_q;
	logic         accept;
	logic         drop;

	// A pair is kept only if there is room for it
	assign accept = adc_strobe_i & ~fifo_full_i;
	assign drop   = adc_strobe_i & fifo_full_i;

	////////////////////////////////////////////////////////////////////////////
	// Word register and write strobe

	always_ff @(posedge GMII_GTX_CLK_int or posedge rst_100) begin
		if (rst_100) begin
			wr_q <= 1'b0;
		end else begin
			wr_q <= accept;  // One cycle per accepted pair
		end
	end

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (accept) begin
			word_q.cha <= adc_cha_i;
			word_q.chb <= adc_chb_i;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Loss counter

	always_ff @(posedge GMII_GTX_CLK_int or posedge rst_100) begin
		if (rst_100) begin
			drop_q <= '0;
		end else if (drop && (drop_q != '1)) begin
			drop_q <= drop_q + 1'b1;  // Sticks at all ones
		end
	end

	assign fifo_wr_o      = wr_q;
	assign fifo_wr_data_o = word_q;
	assign drop_count_o   = drop_q;

endmodule

// ==== design/adc_stream_defines.svh ====
`ifndef ADC_STREAM_DEFINES_SVH
`define ADC_STREAM_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Stream sizing

`define ADC_PACKET_WORDS        16  // Payload words per frame
`define SAMPLE_FIFO_DEPTH_LOG2  6   // 64 words of buffering

////////////////////////////////////////////////////////////////////////////
// Ethernet frame constants

`define MY_MAC          48'h0037_ffff_3737
`define DST_MAC         48'h0090_f5de_6431
`define ADC_ETHERTYPE   16'h88b5    // Local experimental EtherType

`define PREAMBLE_BYTES  7
`define IFG_BYTES       12          // Minimum idle between frames
`define PREAMBLE_BYTE   8'h55
`define SFD_BYTE        8'hd5

`endif

// ==== design/adc_stream_pkg.sv ====
`include "adc_stream_defines.svh"

package adc_stream_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sample side

	// One converter channel
	typedef logic [15:0] adc_sample_t;

	// Channel A in [31:16], channel B in [15:0]
	typedef struct packed {
		adc_sample_t cha;
		adc_sample_t chb;
	} sample_word_t;

	// Count of samples lost to a full FIFO
	typedef logic [15:0] drop_count_t;

	////////////////////////////////////////////////////////////////////////////
	// Buffer and line side

	// Fill level, one bit wider than the pointers so that full is representable
	typedef logic [`SAMPLE_FIFO_DEPTH_LOG2:0] fifo_level_t;

	typedef logic [7:0] gmii_byte_t;  // One GMII transmit byte

endpackage

// ==== design/adc_stream_top.sv ====
`timescale 1ns/1ps

module adc_stream_top (
	input  logic                        GMII_GTX_CLK_int,
	input  logic                        rst_100,
	input  logic                        adc_strobe_i,
	input  adc_stream_pkg::adc_sample_t adc_cha_i,
	input  adc_stream_pkg::adc_sample_t adc_chb_i,
	output adc_stream_pkg::gmii_byte_t  gmii_txd_o,
	output logic                        gmii_tx_en_o,
	output logic                        gmii_tx_er_o,
	output adc_stream_pkg::drop_count_t drop_count_o
);
	import adc_stream_pkg::*;

	logic         fifo_wr;
	sample_word_t fifo_wr_data;
	logic         fifo_full;
	sample_word_t fifo_rd_data;
	logic         packet_avail;
	logic         fifo_rd;

	// Sample pairs into words
	adc_sample_packer adc_sample_packer_i (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_100          (rst_100),
		.adc_strobe_i     (adc_strobe_i),
		.adc_cha_i        (adc_cha_i),
		.adc_chb_i        (adc_chb_i),
		.fifo_full_i      (fifo_full),
		.fifo_wr_o        (fifo_wr),
		.fifo_wr_data_o   (fifo_wr_data),
		.drop_count_o     (drop_count_o)
	);

	sample_fifo sample_fifo_i (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_100          (rst_100),
		.wr_i             (fifo_wr),
		.wr_data_i        (fifo_wr_data),
		.rd_i             (fifo_rd),
		.rd_data_o        (fifo_rd_data),
		.full_o           (fifo_full),
		.packet_avail_o   (packet_avail)
	);

	// Words out as raw Ethernet frames
	packet_sender packet_sender_i (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_100          (rst_100),
		.packet_avail_i   (packet_avail),
		.fifo_data_i      (fifo_rd_data),
		.fifo_rd_o        (fifo_rd),
		.gmii_txd_o       (gmii_txd_o),
		.gmii_tx_en_o     (gmii_tx_en_o),
		.gmii_tx_er_o     (gmii_tx_er_o)
	);

endmodule

// ==== design/packet_sender.sv ====
`timescale 1ns/1ps
`include "adc_stream_defines.svh"

module packet_sender (
	input  logic                         GMII_GTX_CLK_int,
	input  logic                         rst_100,
	input  logic                         packet_avail_i,
	input  adc_stream_pkg::sample_word_t fifo_data_i,
	output logic                         fifo_rd_o,
	output adc_stream_pkg::gmii_byte_t   gmii_txd_o,
	output logic                         gmii_tx_en_o,
	output logic                         gmii_tx_er_o
);
	import adc_stream_pkg::*;

	localparam int          PAYLOAD_BYTES = `ADC_PACKET_WORDS * 4;
	localparam int          CNT_W         = $clog2(PAYLOAD_BYTES);
	localparam logic [47:0] DST_ADDR      = `DST_MAC;
	localparam logic [47:0] SRC_ADDR      = `MY_MAC;
	localparam logic [15:0] ETH_TYPE      = `ADC_ETHERTYPE;

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_PREAMBLE,
		ST_SFD,
		ST_DST,
		ST_SRC,
		ST_TYPE,
		ST_SEQ,
		ST_PAYLOAD,
		ST_GAP
	} state_t;

	state_t           state;
	state_t           state_next;
	logic [CNT_W-1:0] byte_cnt;
	logic [CNT_W-1:0] phase_last;
	logic             last_byte;
	logic [15:0]      seq_q;
	gmii_byte_t       txd_d;
	logic             tx_en_d;
	gmii_byte_t       txd_q;
	logic             tx_en_q;
	logic             tx_er_q;

	////////////////////////////////////////////////////////////////////////////
	// Phase lengths and sequencing

	always_comb begin
		case (state)
			ST_PREAMBLE: phase_last = CNT_W'(`PREAMBLE_BYTES - 1);
			ST_DST,
			ST_SRC:      phase_last = CNT_W'(5);  // 6 address bytes
			ST_TYPE,
			ST_SEQ:      phase_last = CNT_W'(1);
			ST_PAYLOAD:  phase_last = CNT_W'(PAYLOAD_BYTES - 1);
			ST_GAP:      phase_last = CNT_W'(`IFG_BYTES - 1);
			default:     phase_last = '0;       // Idle and SFD last one byte
		endcase
	end

	assign last_byte = (byte_cnt == phase_last);

	always_comb begin
		case (state)
			ST_PREAMBLE: state_next = ST_SFD;
			ST_SFD:      state_next = ST_DST;
			ST_DST:      state_next = ST_SRC;
			ST_SRC:      state_next = ST_TYPE;
			ST_TYPE:     state_next = ST_SEQ;
			ST_SEQ:      state_next = ST_PAYLOAD;
			ST_PAYLOAD:  state_next = ST_GAP;
			default:     state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge GMII_GTX_CLK_int or posedge rst_100) begin
		if (rst_100) begin
			state    <= ST_IDLE;
			byte_cnt <= '0;
			seq_q    <= '0;
		end else if (state == ST_IDLE) begin
			byte_cnt <= '0;
			if (packet_avail_i)
				state <= ST_PREAMBLE;  // A whole payload is already buffered
		end else if (last_byte) begin
			byte_cnt <= '0;
			state    <= state_next;
			if (state == ST_PAYLOAD)
				seq_q <= seq_q + 1'b1;  // Next frame number, wraps
		end else begin
			byte_cnt <= byte_cnt + 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Byte mux, most significant byte first

	always_comb begin
		txd_d   = '0;
		tx_en_d = 1'b1;
		case (state)
			ST_PREAMBLE: txd_d = `PREAMBLE_BYTE;
			ST_SFD:      txd_d = `SFD_BYTE;
			ST_DST:      txd_d = DST_ADDR[8 * (5 - int'(byte_cnt)) +: 8];
			ST_SRC:      txd_d = SRC_ADDR[8 * (5 - int'(byte_cnt)) +: 8];
			ST_TYPE:     txd_d = ETH_TYPE[8 * (1 - int'(byte_cnt)) +: 8];
			ST_SEQ:      txd_d = seq_q[8 * (1 - int'(byte_cnt)) +: 8];
			ST_PAYLOAD:  txd_d = fifo_data_i[8 * (3 - int'(byte_cnt[1:0])) +: 8];
			default:     tx_en_d = 1'b0;
		endcase
	end

	// Pop as the last byte of the head word goes out
	assign fifo_rd_o = (state == ST_PAYLOAD) && (byte_cnt[1:0] == 2'b11);

	////////////////////////////////////////////////////////////////////////////
	// Output register stage in front of the pins

	always_ff @(posedge GMII_GTX_CLK_int or posedge rst_100) begin
		if (rst_100) begin
			txd_q   <= '0;
			tx_en_q <= 1'b0;
			tx_er_q <= 1'b0;
		end else begin
			txd_q   <= txd_d;
			tx_en_q <= tx_en_d;
			tx_er_q <= 1'b0;  // Never signal a coding error
		end
	end

	assign gmii_txd_o   = txd_q;
	assign gmii_tx_en_o = tx_en_q;
	assign gmii_tx_er_o = tx_er_q;

endmodule

// ==== design/sample_fifo.sv ====
`timescale 1ns/1ps
`include "adc_stream_defines.svh"

module sample_fifo #(
	parameter int DEPTH_LOG2 = `SAMPLE_FIFO_DEPTH_LOG2
) (
	input  logic                         GMII_GTX_CLK_int,
	input  logic                         rst_100,
	input  logic                         wr_i,
	input  adc_stream_pkg::sample_word_t wr_data_i,
	input  logic                         rd_i,
	output adc_stream_pkg::sample_word_t rd_data_o,
	output logic                         full_o,
	output logic                         packet_avail_o
);
	import adc_stream_pkg::*;

	localparam int          DEPTH        = 1 << DEPTH_LOG2;
	localparam fifo_level_t LEVEL_FULL   = fifo_level_t'(DEPTH);
	localparam fifo_level_t LEVEL_PACKET = fifo_level_t'(`ADC_PACKET_WORDS);

	sample_word_t          mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wr_ptr;
	logic [DEPTH_LOG2-1:0] rd_ptr;
	fifo_level_t           level;
	fifo_level_t           level_next;
	logic                  packet_avail_q;

	////////////////////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (wr_i) begin
			mem[wr_ptr] <= wr_data_i;
		end
	end

	// Show-ahead, head word always on the output
	assign rd_data_o = mem[rd_ptr];

	////////////////////////////////////////////////////////////////////////////
	// Pointers and fill level

	always_comb begin
		case ({wr_i, rd_i})
			2'b10:   level_next = level + 1'b1;
			2'b01:   level_next = level - 1'b1;
			default: level_next = level;  // Idle, or push and pop together
		endcase
	end

	always_ff @(posedge GMII_GTX_CLK_int or posedge rst_100) begin
		if (rst_100) begin
			wr_ptr         <= '0;
			rd_ptr         <= '0;
			level          <= '0;
			packet_avail_q <= 1'b0;
		end else begin
			if (wr_i)
				wr_ptr <= wr_ptr + 1'b1;  // Wraps at the depth
			if (rd_i)
				rd_ptr <= rd_ptr + 1'b1;
			level          <= level_next;
			packet_avail_q <= (level_next >= LEVEL_PACKET);
		end
	end

	// The write already under way takes the last free slot
	assign full_o = (level == LEVEL_FULL) ||
		(wr_i && (level == LEVEL_FULL - 1'b1));

	assign packet_avail_o = packet_avail_q;

endmodule

// ==== src.f ====
+incdir+design
design/adc_stream_pkg.sv
design/adc_sample_packer.sv
design/sample_fifo.sv
design/packet_sender.sv
design/adc_stream_top.sv
tests/tb_adc_stream.sv

// ==== tests/tb_adc_stream.sv ====
`timescale 1ns/1ps
`include "adc_stream_defines.svh"

module tb_adc_stream;
	import adc_stream_pkg::*;

	localparam int PAYLOAD_BYTES  = 4 * `ADC_PACKET_WORDS;
	localparam int HEADER_BYTES   = `PREAMBLE_BYTES + 1 + 6 + 6 + 2 + 2;
	localparam int FRAME_BYTES    = HEADER_BYTES + PAYLOAD_BYTES;  // 88 bytes on the wire
	localparam int PHASE1_STROBES = 160;
	localparam int PHASE2_STROBES = 200;
	localparam int DRAIN_CYCLES   = 400;
	// About 160 * 13 + 200 + 400 cycles of stimulus, doubled for frames in flight
	localparam int TIMEOUT_CYCLES = 6000;

	logic         GMII_GTX_CLK_int;
	logic         rst_100;
	logic         adc_strobe_i;
	adc_sample_t  adc_cha_i;
	adc_sample_t  adc_chb_i;
	gmii_byte_t   gmii_txd_o;
	logic         gmii_tx_en_o;
	logic         gmii_tx_er_o;
	drop_count_t  drop_count_o;

	integer       seed;
	int           phase;
	int           cycle_count = 0;
	int           strobe_count = 0;
	int           words_rx = 0;
	int           frame_count = 0;
	int           byte_idx = 0;
	int           gap_cycles = 0;
	int           post_reset_cycles = 0;
	logic         tx_en_prev = 1'b0;
	logic [31:0]  word_acc;
	sample_word_t exp_q[$];        // Strobed words in order
	bit           droppable_q[$];  // Set for words that may be lost to overflow

	adc_stream_top adc_stream_top_i (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.rst_100          (rst_100),
		.adc_strobe_i     (adc_strobe_i),
		.adc_cha_i        (adc_cha_i),
		.adc_chb_i        (adc_chb_i),
		.gmii_txd_o       (gmii_txd_o),
		.gmii_tx_en_o     (gmii_tx_en_o),
		.gmii_tx_er_o     (gmii_tx_er_o),
		.drop_count_o     (drop_count_o)
	);

	always #10 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;

	////////////////////////////////////////////////////////////////////////////
	// Error reporting

	task automatic report_failure(input string what);
		$display("=== FAIL ===");
		$display("%s", what);
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_mismatch(input string test_name, input logic [63:0] expected,
			input logic [63:0] actual);
		report_failure($sformatf("mismatch in %s: expected %0h, actual %0h",
			test_name, expected, actual));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model

	// Header bytes in wire order, first byte in the top bits
	function automatic logic [7:0] header_byte(input int idx, input logic [15:0] seq);
		logic [8*HEADER_BYTES-1:0] hdr;
		hdr = {{`PREAMBLE_BYTES{`PREAMBLE_BYTE}}, `SFD_BYTE, 48'(`DST_MAC), 48'(`MY_MAC),
			16'(`ADC_ETHERTYPE), seq};
		return hdr[8 * (HEADER_BYTES - 1 - idx) +: 8];
	endfunction

	// Received words must follow the strobe order, skipping only droppable ones
	task automatic check_payload_word(input sample_word_t got);
		sample_word_t exp_word;
		bit           may_drop;
		bit           found;
		found = 1'b0;
		while (!found && exp_q.size() > 0) begin
			exp_word = exp_q.pop_front();
			may_drop = droppable_q.pop_front();
			if (exp_word == got)
				found = 1'b1;
			else
				assert (may_drop) else report_mismatch("payload_word", exp_word, got);
		end
		assert (found)
		else report_failure($sformatf("payload word %h matches no strobed sample pair", got));
		words_rx++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// GMII frame parser, sampled on the falling edge

	always @(negedge GMII_GTX_CLK_int) begin
		if (rst_100 || post_reset_cycles < 4) begin
			assert (gmii_tx_en_o === 1'b0 && gmii_txd_o === 8'h00)
			else report_mismatch("reset_state", 9'h000, {gmii_tx_en_o, gmii_txd_o});
			assert (drop_count_o === 16'h0000)
			else report_mismatch("reset_drop_count", 0, drop_count_o);
		end
		if (!rst_100)
			post_reset_cycles++;
		assert (gmii_tx_er_o === 1'b0) else report_failure("gmii_tx_er_o was not low");
		if (phase == 1)
			assert (drop_count_o === 16'h0000)
			else report_mismatch("phase1_drops", 0, drop_count_o);

		if (gmii_tx_en_o) begin
			if (!tx_en_prev) begin
				if (frame_count > 0)
					assert (gap_cycles >= `IFG_BYTES)
					else report_mismatch("interframe_gap", `IFG_BYTES, gap_cycles);
				byte_idx = 0;  // Start of a new frame
			end
			assert (byte_idx < FRAME_BYTES) else report_failure("frame longer than 88 bytes");
			if (byte_idx < HEADER_BYTES) begin
				assert (gmii_txd_o === header_byte(byte_idx, frame_count[15:0]))
				else report_mismatch((byte_idx < HEADER_BYTES - 2) ? "frame_header" :
					"sequence_number", header_byte(byte_idx, frame_count[15:0]), gmii_txd_o);
			end else begin
				word_acc = {word_acc[23:0], gmii_txd_o};
				if ((byte_idx - HEADER_BYTES) % 4 == 3)
					check_payload_word(word_acc);
			end
			byte_idx++;
		end else begin
			if (tx_en_prev) begin
				assert (byte_idx == FRAME_BYTES)
				else report_mismatch("frame_length", FRAME_BYTES, byte_idx);
				frame_count++;
				gap_cycles = 0;
			end
			gap_cycles++;
		end
		tx_en_prev = gmii_tx_en_o;
	end

	always @(posedge GMII_GTX_CLK_int) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
			report_failure($sformatf("timeout, run still going after %0d cycles", cycle_count));
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus

	task automatic drive_strobe(input bit may_drop);
		sample_word_t w;
		w = $random(seed);
		adc_strobe_i = 1'b1;
		adc_cha_i    = w.cha;
		adc_chb_i    = w.chb;
		exp_q.push_back(w);
		droppable_q.push_back(may_drop);
		strobe_count++;
		@(posedge GMII_GTX_CLK_int);
		#2;
	endtask

	task automatic idle_cycles(input int n);
		adc_strobe_i = 1'b0;
		repeat (n) @(posedge GMII_GTX_CLK_int);
		#2;
	endtask

	initial begin
		int i;
		int residual;
		seed             = 32'h4745;
		phase            = 0;
		GMII_GTX_CLK_int = 1'b0;
		rst_100          = 1'b1;
		adc_strobe_i     = 1'b0;
		adc_cha_i        = '0;
		adc_chb_i        = '0;
		repeat (10) @(posedge GMII_GTX_CLK_int);
		#2;
		rst_100 = 1'b0;
		idle_cycles(4);

		// Phase 1, spaced strobes, nothing may be lost
		phase = 1;
		for (i = 0; i < PHASE1_STROBES; i++) begin
			drive_strobe(1'b0);
			idle_cycles(7 + ($unsigned($random(seed)) % 6));
		end
		while (frame_count < PHASE1_STROBES / `ADC_PACKET_WORDS || exp_q.size() != 0)
			@(posedge GMII_GTX_CLK_int);
		#2;

		// Phase 2, back to back until the FIFO overflows
		phase = 2;
		for (i = 0; i < PHASE2_STROBES; i++)
			drive_strobe(1'b1);
		idle_cycles(DRAIN_CYCLES);

		assert (drop_count_o != 0) else report_failure("no sample was dropped in phase 2");
		residual = strobe_count - int'(drop_count_o) - words_rx;  // Words left in the FIFO
		assert (residual >= 0 && residual < `ADC_PACKET_WORDS)
		else report_mismatch("overflow_accounting", `ADC_PACKET_WORDS - 1, residual);

		$display("=== PASS ===");
		$finish;
	end

endmodule
